// File: mult_pkg.sv
`default_nettype none

package mult_pkg;

    localparam int WIDTH  = 16;           // Operand width
    localparam int PROD_W = 2 * WIDTH;    // Full signed product
    localparam int CNT_W  = 5;            // Holds 0 to WIDTH

    typedef logic signed [WIDTH-1:0]  operand_t;
    typedef logic signed [PROD_W-1:0] product_t;
    typedef logic        [CNT_W-1:0]  count_t;

    // Two-state sequencer for the add-and-shift loop
    typedef enum logic {
        IDLE = 1'b0,
        CALC = 1'b1
    } ctrl_state_e;

endpackage : mult_pkg

`default_nettype wire

// File: mult_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mult_ctrl_if
    import mult_pkg::*;
;

    // Controller to datapath strobes
    logic en_in;       // Load operands, clear accumulator and counter
    logic bit_sel;     // Add multiplicand instead of zero
    logic count_lb;    // Last step subtracts
    logic count_en;    // Step and advance counter
    logic clr;         // Clear counter

    // Datapath to controller status
    logic bit_01;      // Current multiplier bit
    logic count_last;  // Count at WIDTH-1
    logic count_done;  // Count at WIDTH

    modport ctrl (
        output en_in, bit_sel, count_lb, count_en, clr,
        input  bit_01, count_last, count_done
    );

    modport dp (
        input  en_in, bit_sel, count_lb, count_en, clr,
        output bit_01, count_last, count_done
    );

endinterface : mult_ctrl_if

`default_nettype wire

// File: mult_controller.sv
`timescale 1ns/1ps
`default_nettype none

module mult_controller
    import mult_pkg::*;
(
    input  logic             clk,
    input  logic             n_rst,

    input  logic             start,     // Level sampled only in IDLE

    mult_ctrl_if.ctrl        ctl,

    output logic             ready      // One-cycle result strobe
);

    ctrl_state_e c_state;
    ctrl_state_e n_state;

    always_ff @(posedge clk or negedge n_rst) begin : state_register
        if (!n_rst) begin
            c_state <= IDLE;
        end else begin
            c_state <= n_state;
        end
    end

    always_comb begin : next_state_logic
        n_state = c_state;
        case (c_state)
            IDLE: begin
                if (start) begin
                    n_state = CALC;
                end
            end
            CALC: begin
                if (ctl.count_done) begin
                    n_state = IDLE;         // Leaves one edge after ready
                end
            end
            default: begin
                n_state = IDLE;
            end
        endcase
    end

    // Strobes decoded purely from state, start and datapath flags
    always_comb begin : strobe_decode
        ctl.en_in    = 1'b0;
        ctl.bit_sel  = 1'b0;
        ctl.count_lb = 1'b0;
        ctl.count_en = 1'b0;
        ctl.clr      = 1'b0;
        ready        = 1'b0;

        case (c_state)
            IDLE: begin
                ctl.en_in = start;          // Capture on the accepting edge
            end

            CALC: begin
                if (ctl.count_done) begin
                    ctl.clr = 1'b1;
                    ready   = 1'b1;
                end else begin
                    ctl.count_en = 1'b1;
                    ctl.bit_sel  = ctl.bit_01;
                    ctl.count_lb = ctl.count_last;  // Sign correction step
                end
            end

            default: begin
                ctl.en_in = 1'b0;
            end
        endcase
    end

    // Single result pulse with the step counter cleared behind it
    a_ready_single_cycle : assert property (
        @(posedge clk) disable iff (!n_rst)
        ready |=> !ready && !ctl.count_done
    ) else $error("ready high in two consecutive cycles or count not cleared");

    // ready only in CALC right after the subtract step
    a_ready_in_calc : assert property (
        @(posedge clk) disable iff (!n_rst)
        ready |-> (c_state == CALC) && $past(ctl.count_lb)
    ) else $error("ready outside CALC or not right after the last step");

endmodule : mult_controller

`default_nettype wire

// File: mult_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module mult_datapath
    import mult_pkg::*;
(
    input  logic             clk,
    input  logic             n_rst,

    input  operand_t         multiplicand,
    input  operand_t         multiplier,

    mult_ctrl_if.dp          ctl,

    output product_t         product
);

    operand_t                mcand_q;     // Held multiplicand
    product_t                prod_q;      // Accumulator in high half and multiplier in low half
    count_t                  cnt_q;       // Step counter 0 to WIDTH

    logic signed [WIDTH:0]   acc_ext;     // High half plus guard bit
    logic signed [WIDTH:0]   addend_ext;
    logic signed [WIDTH:0]   sum;

    // Multiplicand register loaded once per operation
    always_ff @(posedge clk) begin : mcand_register
        if (ctl.en_in) begin
            mcand_q <= multiplicand;
        end
    end

    // Add or subtract into the high half with one guard bit
    always_comb begin : add_sub
        acc_ext    = {prod_q[PROD_W-1], prod_q[PROD_W-1:WIDTH]};
        addend_ext = '0;
        if (ctl.bit_sel) begin
            addend_ext = {mcand_q[WIDTH-1], mcand_q};
        end
        if (ctl.count_lb) begin
            sum = acc_ext - addend_ext;     // Weight of sign bit is negative
        end else begin
            sum = acc_ext + addend_ext;
        end
    end

    // Arithmetic right shift by one per step
    always_ff @(posedge clk or negedge n_rst) begin : product_register
        if (!n_rst) begin
            prod_q <= '0;
        end else if (ctl.en_in) begin
            prod_q <= {{WIDTH{1'b0}}, multiplier};
        end else if (ctl.count_en) begin
            prod_q <= {sum, prod_q[WIDTH-1:1]};   // Guard bit becomes new MSB
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin : step_counter
        if (!n_rst) begin
            cnt_q <= '0;
        end else if (ctl.en_in || ctl.clr) begin
            cnt_q <= '0;
        end else if (ctl.count_en) begin
            cnt_q <= cnt_q + count_t'(1);
        end
    end

    assign ctl.bit_01     = prod_q[0];
    assign ctl.count_last = (cnt_q == count_t'(WIDTH - 1));
    assign ctl.count_done = (cnt_q == count_t'(WIDTH));

    assign product = prod_q;

    // Load and step never overlap
    a_load_step_exclusive : assert property (
        @(posedge clk) disable iff (!n_rst)
        !(ctl.en_in && ctl.count_en)
    ) else $error("en_in and count_en high together");

    // Counter never runs past WIDTH
    a_count_bounded : assert property (
        @(posedge clk) disable iff (!n_rst)
        cnt_q <= count_t'(WIDTH)
    ) else $error("step count above WIDTH");

endmodule : mult_datapath

`default_nettype wire

// File: mult_top.sv
`timescale 1ns/1ps
`default_nettype none

module mult_top
    import mult_pkg::*;
(
    input  logic             clk,
    input  logic             n_rst,

    input  logic             start,
    input  operand_t         multiplicand,
    input  operand_t         multiplier,

    output product_t         product,
    output logic             ready
);

    // Strobes and status between FSM and datapath
    mult_ctrl_if i_ctrl_if ();

    mult_controller i_controller (
        .clk    (clk),
        .n_rst  (n_rst),
        .start  (start),
        .ctl    (i_ctrl_if.ctrl),
        .ready  (ready)
    );

    mult_datapath i_datapath (
        .clk          (clk),
        .n_rst        (n_rst),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .ctl          (i_ctrl_if.dp),
        .product      (product)
    );

endmodule : mult_top

`default_nettype wire

// File: tb_mult.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mult
    import mult_pkg::*;
;

    localparam int N_RANDOM   = 200;
    localparam int N_OPS      = 6 + N_RANDOM + 8;     // Corners, random, directed
    localparam int MAX_CYCLES = N_OPS * 20 + 100;
    localparam int READY_WAIT = 24;                   // Cycles allowed for one result

    logic     clk;
    logic     n_rst;
    logic     start;
    operand_t multiplicand;
    operand_t multiplier;
    product_t product;
    logic     ready;

    logic [15:0] lfsr_state;
    int          cycle;
    int          value_errors;
    int          protocol_errors;
    int          results_checked;

    // Expected protocol state, follows accepted starts
    logic     busy;
    int       steps;
    operand_t exp_a;
    operand_t exp_b;

    logic     ready_exp;
    logic     ready_prev;
    product_t held_prod;

    mult_top i_dut (
        .clk          (clk),
        .n_rst        (n_rst),
        .start        (start),
        .multiplicand (multiplicand),
        .multiplier   (multiplier),
        .product      (product),
        .ready        (ready)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin : cycle_count
        cycle <= cycle + 1;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic lsb;
        lsb = s[0];
        s   = s >> 1;
        if (lsb) begin
            s = s ^ 16'hB400;
        end
        return s;
    endfunction

    // One LFSR step per operand bit
    task automatic draw_operand(output operand_t value);
        value = '0;
        for (int i = 0; i < WIDTH; i++) begin
            value      = {value[WIDTH-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic product_t exp_product(input operand_t a, input operand_t b);
        return product_t'(a) * product_t'(b);
    endfunction

    task automatic check_product(input string what, input operand_t a, input operand_t b,
                                 input product_t expected, input product_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("MISMATCH at %0t: %s product of %0d x %0d, expected %0d, got %0d",
                     $time, what, a, b, expected, actual);
        end
    endtask

    task automatic check_ready(input logic expected, input logic actual, input logic prev);
        if (actual !== expected) begin
            protocol_errors++;
            if (expected) begin
                $display("At %0t: ready did not arrive 16 cycles after the accepted start",
                         $time);
            end else if (prev) begin
                $display("At %0t: ready stayed high for more than one cycle", $time);
            end else begin
                $display("At %0t: ready was high outside the result cycle", $time);
            end
        end
    endtask

    // Start is only taken in IDLE, the result cycle follows 16 steps later
    always @(posedge clk or negedge n_rst) begin : protocol_model
        if (!n_rst) begin
            busy  <= 1'b0;
            steps <= 0;
        end else if (!busy) begin
            if (start) begin
                busy  <= 1'b1;
                steps <= 0;
                exp_a <= multiplicand;
                exp_b <= multiplier;
            end
        end else begin
            steps <= steps + 1;
            if (steps == WIDTH) begin
                busy <= 1'b0;
            end
        end
    end

    always @(negedge clk) begin : monitor
        ready_exp = n_rst && busy && (steps == WIDTH);
        check_ready(ready_exp, ready, ready_prev);
        if (!n_rst) begin
            held_prod = '0;
            check_product("reset", '0, '0, '0, product);
        end else if (ready_exp && ready === 1'b1) begin
            held_prod = exp_product(exp_a, exp_b);
            check_product("result", exp_a, exp_b, held_prod, product);
            results_checked++;
        end else if (!busy) begin
            check_product("held", exp_a, exp_b, held_prod, product);   // Stable while idle
        end
        ready_prev = ready;
    end

    task automatic wait_ready();
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (ready !== 1'b1 && waited < READY_WAIT);
    endtask

    task automatic do_mult(input operand_t a, input operand_t b);
        @(posedge clk);
        start        <= 1'b1;
        multiplicand <= a;
        multiplier   <= b;
        @(posedge clk);
        start <= 1'b0;                  // Accepting edge
        wait_ready();
        @(posedge clk);
    endtask

    initial begin : watchdog
        while (cycle < MAX_CYCLES) begin
            @(posedge clk);
        end
        protocol_errors++;
        $display("Run stopped after %0d cycles without finishing the tests", cycle);
        $display("value errors: %0d, protocol errors: %0d, results checked: %0d",
                 value_errors, protocol_errors, results_checked);
        $display("Done: errors found");
        $finish;
    end

    initial begin : stimulus
        operand_t a;
        operand_t b;

        clk             = 1'b0;
        n_rst           = 1'b0;
        start           = 1'b0;
        multiplicand    = '0;
        multiplier      = '0;
        lfsr_state      = 16'd58;
        cycle           = 0;
        value_errors    = 0;
        protocol_errors = 0;
        results_checked = 0;
        ready_prev      = 1'b0;
        held_prod       = '0;

        repeat (5) @(posedge clk);
        n_rst <= 1'b1;
        repeat (3) @(posedge clk);      // Idle, ready low and product zero

        draw_operand(a);
        do_mult(16'sd0, a);
        do_mult(16'sd1, -16'sd1);
        do_mult(-16'sd1, -16'sd1);
        do_mult(-16'sd32768, -16'sd32768);
        do_mult(-16'sd32768, 16'sd32767);
        do_mult(16'sd32767, 16'sd32767);

        for (int i = 0; i < N_RANDOM; i++) begin
            draw_operand(a);
            draw_operand(b);
            do_mult(a, b);
        end

        // Start held high through the whole calculation
        draw_operand(a);
        draw_operand(b);
        @(posedge clk);
        start        <= 1'b1;
        multiplicand <= a;
        multiplier   <= b;
        wait_ready();
        @(posedge clk);
        start <= 1'b0;
        repeat (2) @(posedge clk);

        // Start raised in the ready cycle, taken on the first IDLE edge
        draw_operand(a);
        draw_operand(b);
        do_mult(a, b);
        draw_operand(a);
        draw_operand(b);
        @(posedge clk);
        start        <= 1'b1;
        multiplicand <= a;
        multiplier   <= b;
        @(posedge clk);
        start <= 1'b0;
        repeat (WIDTH) @(posedge clk);
        draw_operand(a);
        draw_operand(b);
        start        <= 1'b1;
        multiplicand <= a;
        multiplier   <= b;
        wait_ready();
        @(posedge clk);
        @(posedge clk);
        start <= 1'b0;
        wait_ready();
        @(posedge clk);

        // Operands move during and after the calculation
        draw_operand(a);
        draw_operand(b);
        @(posedge clk);
        start        <= 1'b1;
        multiplicand <= a;
        multiplier   <= b;
        @(posedge clk);
        start <= 1'b0;
        for (int i = 0; i < 8; i++) begin
            draw_operand(a);
            draw_operand(b);
            @(posedge clk);
            multiplicand <= a;
            multiplier   <= b;
        end
        wait_ready();
        for (int i = 0; i < 6; i++) begin
            draw_operand(a);
            draw_operand(b);
            @(posedge clk);
            multiplicand <= a;
            multiplier   <= b;
        end

        // Reset in the middle of a calculation
        draw_operand(a);
        draw_operand(b);
        @(posedge clk);
        start        <= 1'b1;
        multiplicand <= a;
        multiplier   <= b;
        @(posedge clk);
        start <= 1'b0;
        repeat (7) @(posedge clk);
        n_rst <= 1'b0;
        repeat (2) @(posedge clk);
        n_rst <= 1'b1;
        repeat (2) @(posedge clk);
        draw_operand(a);
        draw_operand(b);
        do_mult(a, b);

        repeat (4) @(posedge clk);
        $display("value errors: %0d, protocol errors: %0d, results checked: %0d",
                 value_errors, protocol_errors, results_checked);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule : tb_mult

`default_nettype wire

// File: vlog.f
mult_pkg.sv
mult_ctrl_if.sv
mult_controller.sv
mult_datapath.sv
mult_top.sv
tb_mult.sv

// File: Bender.yml
package:
  name: mult

sources:
  - mult_pkg.sv
  - mult_ctrl_if.sv
  - mult_controller.sv
  - mult_datapath.sv
  - mult_top.sv
  - target: test
    files:
      - tb_mult.sv
